// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = nes_video_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

# the palette file is loaded by name, so the model runs from design/
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	cd design && ../$(OBJ_DIR)/V$(TOP) 2>&1 | tee ../$(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
design/nes_video_pkg.sv
design/nes_palette_decode.sv
design/line_doubler.sv
design/video_output_stage.sv
design/nes_video_top.sv
verification/nes_video_chk.sv
verification/nes_video_tb.sv

// ==== design/line_doubler.sv ====
/* Line doubler
   two line buffers plus the output raster counters, locked once per NES frame */
`timescale 1ns/1ps
`default_nettype none

module line_doubler import nes_video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  wr_word_t   wr,
	input  logic       pix_ce,
	input  logic [8:0] count_h,
	input  logic [8:0] count_v,
	output raster_t    raster,
	output rgb_t       pixel
);

	// one buffer per NES line parity
	rgb_t line_buf [0:1][0:LINE_DEPTH-1];

	coord_t     h;
	coord_t     v;
	logic       h_end;
	logic       v_end;
	logic       frame_lock;
	logic       rd_bank;
	line_addr_t rd_addr;

	// NES dot 0 of line 1 starts output line 0
	assign frame_lock = pix_ce && (count_h == 9'd0) && (count_v == 9'd1);

	assign h_end = (h == H_TOTAL - 10'd1);
	assign v_end = (v == V_TOTAL - 10'd1);

	/*
	 * Free running raster. A NES line is 341 dots of 4 clocks, which is exactly
	 * two output lines of 682 clocks, so after the lock it never drifts.
	 */
	always_ff @(posedge clk) begin
		if (reset) begin
			h <= '0;
			v <= V_PICTURE;  // blank until the first lock
		end else if (frame_lock) begin
			h <= '0;
			v <= '0;
		end else if (h_end) begin
			h <= '0;
			if (v_end)
				v <= '0;
			else
				v <= v + 10'd1;
		end else begin
			h <= h + 10'd1;
		end
	end

	// NES side fills one bank while the other is shown
	always_ff @(posedge clk) begin
		if (wr.we)
			line_buf[wr.bank][wr.addr] <= wr.rgb;
	end

	/*
	 * Output lines 2k and 2k+1 show NES line k, so v bit 1 is its parity.
	 * Dropping h bit 0 repeats each dot over two pixels.
	 */
	assign rd_bank = v[1];
	assign rd_addr = h[LINE_W:1];

	always_ff @(posedge clk) begin
		pixel <= line_buf[rd_bank][rd_addr];
	end

	// raster delayed to line up with the read data
	always_ff @(posedge clk) begin
		if (reset) begin
			raster.h <= '0;
			raster.v <= V_PICTURE;
		end else begin
			raster.h <= h;
			raster.v <= v;
		end
	end

endmodule

`default_nettype wire

// ==== design/nes_palette.hex ====
// RGB555 per NES colour index, one word per line: bits 14:10 blue, 9:5 green, 4:0 red
3DEF
7C00
5C00
5CA8
4012
1015
0055
0051
00CA
01E0
01A0
0160
2D00
0000
0000
0000
5EF7
7DE0
7D60
7D0D
641B
2C1C
00FF
097C
01F5
02E0
02A0
22A0
4620
0000
0000
0000
7FFF
7EE7
7E2D
7DF3
7DFF
4D7F
2DFF
229F
02FF
0FF7
2B6B
4FEB
6FA0
3DEF
0000
0000
7FFF
7F94
7EF7
7EFB
7EFF
629F
5B5E
579F
3F7F
3FFB
5FF7
6FF7
7FE0
7F7F
0000
0000

// ==== design/nes_palette_decode.sv ====
/* NES palette decode
   maps the 6-bit colour index to RGB555 and forms the line-buffer write word */
`timescale 1ns/1ps
`default_nettype none

module nes_palette_decode import nes_video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  color_idx_t color,
	input  logic       pix_ce,
	input  logic [8:0] count_h,
	input  logic [8:0] count_v,
	output wr_word_t   wr
);

	rgb_t palette [0:PAL_DEPTH-1];  // RGB555 per index

	logic visible_dot;

	initial begin
		$readmemh(PALETTE_FILE, palette);
	end

	// dots 0..255 carry picture, 256..340 are blanking
	assign visible_dot = pix_ce && !count_h[8];

	// write strobe is the only control bit here
	always_ff @(posedge clk) begin
		if (reset) begin
			wr.we <= 1'b0;
		end else begin
			wr.we <= visible_dot;
		end
	end

	// payload follows every strobe, whether visible or not
	always_ff @(posedge clk) begin
		if (pix_ce) begin
			wr.rgb  <= palette[color];
			wr.addr <= count_h[LINE_W-1:0];
			wr.bank <= count_v[0];  // even/odd NES line
		end
	end

endmodule

`default_nettype wire

// ==== design/nes_video_pkg.sv ====
/* NES video package
   raster timing, channel widths and the structs shared by the video stages */
`default_nettype none

package nes_video_pkg;

	localparam int COLOR_W    = 6;   // NES palette index
	localparam int CHAN_W     = 5;   // one RGB555 channel
	localparam int LINE_W     = 8;   // visible dots per NES line, as address bits
	localparam int RASTER_W   = 10;  // output counters
	localparam int PAL_DEPTH  = 64;
	localparam int LINE_DEPTH = 256;

	typedef logic [COLOR_W-1:0]  color_idx_t;
	typedef logic [CHAN_W-1:0]   chan_t;
	typedef logic [LINE_W-1:0]   line_addr_t;
	typedef logic [RASTER_W-1:0] coord_t;

	// same bit order as the palette words, blue on top
	typedef struct packed {
		chan_t b;
		chan_t g;
		chan_t r;
	} rgb_t;

	// one write into a line buffer
	typedef struct packed {
		logic       we;
		logic       bank;  // NES line parity
		line_addr_t addr;
		rgb_t       rgb;
	} wr_word_t;

	typedef struct packed {
		coord_t h;
		coord_t v;
	} raster_t;

	// doubled raster, in output pixels and lines
	localparam coord_t H_PICTURE = 10'd512;
	localparam coord_t H_TOTAL   = 10'd682;
	localparam coord_t V_PICTURE = 10'd480;
	localparam coord_t V_TOTAL   = 10'd524;

	localparam coord_t HS_START = 10'd570;
	localparam coord_t HS_LEN   = 10'd82;
	localparam coord_t VS_START = 10'd490;
	localparam coord_t VS_LEN   = 10'd2;

	// border hiding the garbage most games leave at the screen edge
	localparam coord_t OS_LEFT   = 10'd18;
	localparam coord_t OS_RIGHT  = 10'd496;
	localparam coord_t OS_TOP    = 10'd8;
	localparam coord_t OS_BOTTOM = 10'd460;

	localparam string PALETTE_FILE = "nes_palette.hex";

endpackage

`default_nettype wire

// ==== design/nes_video_top.sv ====
/* NES video output top
   palette decode, line doubler and output stage in a chain, all on clk */
`timescale 1ns/1ps
`default_nettype none

module nes_video_top import nes_video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  color_idx_t color,
	input  logic       pix_ce,     // one NES dot every 4 clocks
	input  logic [8:0] count_h,    // NES dot, 0..340
	input  logic [8:0] count_v,    // NES line, 0..261
	input  logic       scanlines,
	input  logic       overscan,
	output rgb_t       rgb,
	output logic       de,
	output logic       hs_n,
	output logic       vs_n
);

	wr_word_t wr;
	raster_t  raster;
	rgb_t     pixel;

	// index to RGB555, one clock after pix_ce
	nes_palette_decode u_decode (
		.clk     (clk),
		.reset   (reset),
		.color   (color),
		.pix_ce  (pix_ce),
		.count_h (count_h),
		.count_v (count_v),
		.wr      (wr)
	);

	// raster and pixel come out together, one clock behind the counter
	line_doubler u_doubler (
		.clk     (clk),
		.reset   (reset),
		.wr      (wr),
		.pix_ce  (pix_ce),
		.count_h (count_h),
		.count_v (count_v),
		.raster  (raster),
		.pixel   (pixel)
	);

	// adds the second clock of delay
	video_output_stage u_output (
		.clk       (clk),
		.reset     (reset),
		.raster    (raster),
		.pixel     (pixel),
		.scanlines (scanlines),
		.overscan  (overscan),
		.rgb       (rgb),
		.de        (de),
		.hs_n      (hs_n),
		.vs_n      (vs_n)
	);

endmodule

`default_nettype wire

// ==== design/video_output_stage.sv ====
/* Video output stage
   scanline dimming, overscan border, data enable and sync, all registered */
`timescale 1ns/1ps
`default_nettype none

module video_output_stage import nes_video_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  raster_t raster,
	input  rgb_t    pixel,
	input  logic    scanlines,
	input  logic    overscan,
	output rgb_t    rgb,
	output logic    de,
	output logic    hs_n,
	output logic    vs_n
);

	logic picture;
	logic border;
	logic dim;
	logic in_hsync;
	logic in_vsync;
	rgb_t shaded;

	// border keeps only the top bit, dimming halves the channel
	function automatic chan_t shade(input chan_t c, input logic edge_px, input logic dark);
		chan_t res;
		if (edge_px)
			res = {{(CHAN_W-1){1'b0}}, c[CHAN_W-1]};
		else if (dark)
			res = {1'b0, c[CHAN_W-1:1]};
		else
			res = c;
		return res;
	endfunction

	assign picture = (raster.h < H_PICTURE) && (raster.v < V_PICTURE);

	assign border = overscan && ((raster.h > OS_RIGHT) ||
		(raster.h < OS_LEFT) ||
		(raster.v < OS_TOP) ||
		(raster.v > OS_BOTTOM));

	assign dim = scanlines && raster.v[0];  // odd output lines only

	assign in_hsync = (raster.h >= HS_START) && (raster.h < HS_START + HS_LEN);
	assign in_vsync = (raster.v >= VS_START) && (raster.v < VS_START + VS_LEN);

	always_comb begin
		shaded.r = shade(pixel.r, border, dim);
		shaded.g = shade(pixel.g, border, dim);
		shaded.b = shade(pixel.b, border, dim);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb  <= '0;
			de   <= 1'b0;
			hs_n <= 1'b1;
			vs_n <= 1'b1;
		end else begin
			rgb  <= picture ? shaded : '0;  // black in blanking
			de   <= picture;
			hs_n <= ~in_hsync;
			vs_n <= ~in_vsync;
		end
	end

endmodule

`default_nettype wire

// ==== verification/nes_video_chk.sv ====
/* NES video timing checker
   sync width, blanking and post-reset state of the top level outputs */
`timescale 1ns/1ps
`default_nettype none

module nes_video_chk import nes_video_pkg::*; (
	input logic clk,
	input logic reset,
	input rgb_t rgb,
	input logic de,
	input logic hs_n,
	input logic vs_n
);

	coord_t hs_low;  // clocks hs_n has been low so far

	always_ff @(posedge clk) begin
		if (reset)
			hs_low <= '0;
		else if (!hs_n)
			hs_low <= hs_low + 10'd1;
		else
			hs_low <= '0;
	end

	hsync_width: assert property (@(posedge clk) disable iff (reset)
		$rose(hs_n) |-> (hs_low == HS_LEN))
		else $error("hs_n pulse lasted %0d clocks", hs_low);

	// picture never overlaps a sync pulse
	de_outside_sync: assert property (@(posedge clk) disable iff (reset)
		de |-> (hs_n && vs_n))
		else $error("de high while a sync pulse is active");

	reset_state: assert property (@(posedge clk)
		$fell(reset) |-> (!de && hs_n && vs_n && (rgb == '0)))
		else $error("outputs active in the cycle after reset");

endmodule

bind nes_video_top nes_video_chk chk0 (
	.clk   (clk),
	.reset (reset),
	.rgb   (rgb),
	.de    (de),
	.hs_n  (hs_n),
	.vs_n  (vs_n)
);

`default_nettype wire

// ==== verification/nes_video_tb.sv ====
/* NES video testbench
   random NES frames through the doubler, every output clock checked against a model */
`timescale 1ns/1ps
`default_nettype none

module nes_video_tb import nes_video_pkg::*; ();

	localparam int CLK_PERIOD    = 40;
	localparam int NES_LINES     = 262;
	localparam int NES_DOTS      = 341;
	localparam int VISIBLE_LINES = 240;
	localparam int FRAME_CLKS    = int'(H_TOTAL) * int'(V_TOTAL);
	localparam int WATCHDOG_CLKS = 4 * FRAME_CLKS;  // three test frames plus slack
	localparam logic [31:0] RNG_SEED = 32'he5a5_35a2;

	typedef struct packed {
		logic de;
		rgb_t rgb;
	} expect_t;

	logic       clk = 1'b0;
	logic       reset;
	color_idx_t color;
	logic       pix_ce;
	logic [8:0] count_h;
	logic [8:0] count_v;
	logic       scanlines;
	logic       overscan;
	rgb_t       rgb;
	logic       de;
	logic       hs_n;
	logic       vs_n;

	rgb_t       pal_ref [0:PAL_DEPTH-1];
	color_idx_t nes_pix [0:VISIBLE_LINES-1][0:LINE_DEPTH-1];  // last frame's visible dots
	raster_t    cnt;
	raster_t    pos_d1;
	raster_t    pos_d2;  // raster position the outputs belong to
	logic       live;

	nes_video_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.color     (color),
		.pix_ce    (pix_ce),
		.count_h   (count_h),
		.count_v   (count_v),
		.scanlines (scanlines),
		.overscan  (overscan),
		.rgb       (rgb),
		.de        (de),
		.hs_n      (hs_n),
		.vs_n      (vs_n)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// expected output for one raster position
	function automatic expect_t expected_pixel(input raster_t pos, input logic scan_on,
		input logic os_on);
		expect_t e;
		rgb_t    base;
		logic    edge_px;
		e.de = (pos.h < H_PICTURE) && (pos.v < V_PICTURE);
		e.rgb = '0;
		if (e.de) begin
			base = pal_ref[nes_pix[pos.v[8:1]][pos.h[8:1]]];  // dot (h/2, v/2)
			edge_px = os_on && ((pos.h < OS_LEFT) || (pos.h > OS_RIGHT) ||
				(pos.v < OS_TOP) || (pos.v > OS_BOTTOM));
			if (edge_px) begin
				e.rgb.r = chan_t'(base.r[CHAN_W-1]);
				e.rgb.g = chan_t'(base.g[CHAN_W-1]);
				e.rgb.b = chan_t'(base.b[CHAN_W-1]);
			end else if (scan_on && pos.v[0]) begin
				e.rgb.r = base.r >> 1;
				e.rgb.g = base.g >> 1;
				e.rgb.b = base.b >> 1;
			end else begin
				e.rgb = base;
			end
		end
		return e;
	endfunction

	// sync level on one axis, low from the first position through first + len - 1
	function automatic logic expected_sync_n(input coord_t pos, input coord_t first,
		input coord_t len);
		return !((pos >= first) && (pos <= first + len - 10'd1));
	endfunction

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t want);
		if (got !== want) begin
			$display("[ERROR] %s got %h expected %h at h=%0d v=%0d", name, got, want,
				pos_d2.h, pos_d2.v);
			$display("Finished with errors");
			$fatal(1, "pixel mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("[ERROR] %s got %h expected %h at h=%0d v=%0d", name, got, want,
				pos_d2.h, pos_d2.v);
			$display("Finished with errors");
			$fatal(1, "control mismatch");
		end
	endtask

	// one NES frame of random dots, pix_ce on every 4th falling edge
	task automatic drive_frame(input logic scan_on, input logic os_on);
		color_idx_t c;
		scanlines = scan_on;  // changed only while the output is in vertical blank
		overscan = os_on;
		for (int nes_line = 0; nes_line < NES_LINES; nes_line++) begin
			for (int nes_dot = 0; nes_dot < NES_DOTS; nes_dot++) begin
				c = color_idx_t'($urandom_range(PAL_DEPTH - 1, 0));
				@(negedge clk);
				pix_ce = 1'b1;
				count_h = 9'(nes_dot);
				count_v = 9'(nes_line);
				color = c;
				if (nes_line < VISIBLE_LINES && nes_dot < LINE_DEPTH)
					nes_pix[nes_line][nes_dot] = c;
				repeat (3) begin
					@(negedge clk);
					pix_ce = 1'b0;
				end
			end
		end
	endtask

	// output raster model, locked like the doubler and delayed two clocks
	always @(posedge clk) begin
		live <= !reset;
		if (reset) begin
			cnt <= '{h: '0, v: V_PICTURE};
			pos_d1 <= '{h: '0, v: V_PICTURE};
			pos_d2 <= '{h: '0, v: V_PICTURE};
		end else begin
			if (pix_ce && count_h == 9'd0 && count_v == 9'd1) begin
				cnt <= '{h: '0, v: '0};
			end else if (cnt.h == H_TOTAL - 10'd1) begin
				cnt.h <= '0;
				cnt.v <= (cnt.v == V_TOTAL - 10'd1) ? '0 : cnt.v + 10'd1;
			end else begin
				cnt.h <= cnt.h + 10'd1;
			end
			pos_d1 <= cnt;
			pos_d2 <= pos_d1;
		end
	end

	always @(negedge clk) begin : compare_outputs
		expect_t want;
		if (live) begin
			want = expected_pixel(pos_d2, scanlines, overscan);
			check_rgb("rgb", rgb, want.rgb);
			check_bit("de", de, want.de);
			check_bit("hs_n", hs_n, expected_sync_n(pos_d2.h, HS_START, HS_LEN));
			check_bit("vs_n", vs_n, expected_sync_n(pos_d2.v, VS_START, VS_LEN));
		end
	end

	initial begin
		reset = 1'b1;
		color = '0;
		pix_ce = 1'b0;
		count_h = '0;
		count_v = '0;
		scanlines = 1'b0;
		overscan = 1'b0;
		void'($urandom(RNG_SEED));
		$readmemh(PALETTE_FILE, pal_ref);
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		drive_frame(1'b0, 1'b0);  // plain doubling
		drive_frame(1'b1, 1'b0);  // scanlines
		drive_frame(1'b1, 1'b1);  // border over scanlines
		repeat (8) @(negedge clk);
		$display("Finished with no errors");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CLKS) @(posedge clk);
		$display("timeout: the test frames did not complete in time");
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
